// File: common/lowlat_phy_cfg.svh
// build-time constants for the PHY management block, included by the package and the RTL
`ifndef LOWLAT_PHY_CFG_SVH
`define LOWLAT_PHY_CFG_SVH

//////////////////////////////
// lane count
//////////////////////////////
`define LOWLAT_LANES 4

//////////////////////////////
// management bus
//////////////////////////////
`define MGMT_ADDR_W 9
`define MGMT_DATA_W 32

// word address map
`define PMA_CTRL_BASE 9'h020
`define CH_BASE 9'h040
`define RECONFIG_BASE 9'h100

//////////////////////////////
// readiness timing
//////////////////////////////
// settling cycles before a lane reports ready
`define TX_READY_DLY 16
`define RX_READY_DLY 24

// depth of every async-to-mgmt-clock synchronizer
`define SYNC_STAGES 2

`endif

// File: common/lowlat_phy_pkg.sv
// shared bus, lane and register-map types, imported by the RTL and the testbench
`include "lowlat_phy_cfg.svh"

package lowlat_phy_pkg;

    // management bus word address and data
    typedef logic [`MGMT_ADDR_W-1:0] mgmt_addr_t;
    typedef logic [`MGMT_DATA_W-1:0] mgmt_data_t;

    // one bit per lane
    typedef logic [`LOWLAT_LANES-1:0] lane_vec_t;

    // decoded slave region
    typedef enum logic [1:0] {
        NONE     = 2'd0,
        PMA_CTRL = 2'd1,
        CHANNEL  = 2'd2,
        RECONFIG = 2'd3
    } mgmt_region_e;

    // PMA controller word offsets
    typedef enum logic [1:0] {
        PLL_PDN     = 2'd0,
        GX_PDN      = 2'd1,
        LOCK_STATUS = 2'd2
    } pma_reg_off_e;

    // channel register word offsets
    typedef enum logic [5:0] {
        LANE_RESET = 6'h00,
        TX_READY   = 6'h01,
        RX_READY   = 6'h02,
        RX_LOCKED  = 6'h03
    } ch_reg_off_e;

endpackage

// File: rtl/phy_mgmt_decoder.sv
// combinational address decoder that splits the management bus across the PHY slaves
`timescale 1ns/1ns
`include "lowlat_phy_cfg.svh"

module phy_mgmt_decoder
    import lowlat_phy_pkg::*;
(
    input  mgmt_addr_t address,
    input  logic       read,
    input  logic       write,
    input  mgmt_data_t pma_readdata,
    input  logic       pma_waitrequest,
    input  mgmt_data_t ch_readdata,
    input  logic       ch_waitrequest,
    output logic       pma_read,
    output logic       pma_write,
    output logic       ch_read,
    output logic       ch_write,
    output mgmt_data_t readdata,
    output logic       waitrequest
);

    // region bases and the address bits that select them
    localparam mgmt_addr_t pma_base      = `PMA_CTRL_BASE;
    localparam mgmt_addr_t ch_base       = `CH_BASE;
    localparam mgmt_addr_t reconfig_base = `RECONFIG_BASE;
    localparam mgmt_addr_t pma_mask      = 9'h1e0;
    localparam mgmt_addr_t ch_mask       = 9'h1c0;
    localparam mgmt_addr_t reconfig_mask = 9'h100;

    mgmt_region_e region;

    //////////////////////////////
    // address classification
    //////////////////////////////
    always_comb
    begin
        if ((address & pma_mask) == pma_base)
            region = PMA_CTRL;
        else if ((address & ch_mask) == ch_base)
            region = CHANNEL;
        else if ((address & reconfig_mask) == reconfig_base)
            region = RECONFIG;
        else
            region = NONE;
    end

    // strobes only reach the selected slave
    assign pma_read  = read  & (region == PMA_CTRL);
    assign pma_write = write & (region == PMA_CTRL);
    assign ch_read   = read  & (region == CHANNEL);
    assign ch_write  = write & (region == CHANNEL);

    //////////////////////////////
    // response merge
    //////////////////////////////
    always_comb
    begin
        case (region)
            PMA_CTRL:
            begin
                readdata    = pma_readdata;
                waitrequest = pma_waitrequest;
            end
            CHANNEL:
            begin
                readdata    = ch_readdata;
                waitrequest = ch_waitrequest;
            end
            // reconfig space is a stub, reads zero and never stalls
            RECONFIG:
            begin
                readdata    = '0;
                waitrequest = 1'b0;
            end
            default:
            begin
                readdata    = '0;
                waitrequest = 1'b0;
            end
        endcase
    end

endmodule

// File: pma_ctrl/pma_ctrl_regs.sv
// PMA controller slave holding the power-down controls and the PLL lock status
`timescale 1ns/1ns
`include "lowlat_phy_cfg.svh"

module pma_ctrl_regs
    import lowlat_phy_pkg::*;
(
    input  logic       phy_mgmt_clk,
    input  logic       rst_n,
    input  logic [1:0] address,
    input  logic       read,
    input  logic       write,
    input  mgmt_data_t writedata,
    input  logic       pll_lock_raw,
    output mgmt_data_t readdata,
    output logic       waitrequest,
    output logic       pll_pdn,
    output logic       gx_pdn,
    output logic       cal_blk_pdn,
    output logic       pll_locked
);

    pma_reg_off_e             offset;
    logic                     rd_done;
    mgmt_data_t               rd_mux;
    logic [`SYNC_STAGES-1:0]  lock_sync;

    assign offset = pma_reg_off_e'(address);

    //////////////////////////////
    // PLL lock synchronizer
    //////////////////////////////
    always_ff @(posedge phy_mgmt_clk or negedge rst_n)
    begin
        if (!rst_n)
            lock_sync <= '0;
        else
            lock_sync <= {lock_sync[`SYNC_STAGES-2:0], pll_lock_raw};
    end

    assign pll_locked = lock_sync[`SYNC_STAGES-1];

    //////////////////////////////
    // control registers
    //////////////////////////////
    always_ff @(posedge phy_mgmt_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pll_pdn     <= 1'b0;
            gx_pdn      <= 1'b0;
            cal_blk_pdn <= 1'b0;
        end
        else if (write)
        begin
            case (offset)
                PLL_PDN:
                    pll_pdn <= writedata[0];
                GX_PDN:
                begin
                    gx_pdn      <= writedata[0];
                    cal_blk_pdn <= writedata[1];
                end
                // lock status is read-only
                default:
                begin
                end
            endcase
        end
    end

    // readback select
    always_comb
    begin
        rd_mux = '0;
        case (offset)
            PLL_PDN:
                rd_mux[0] = pll_pdn;
            GX_PDN:
                rd_mux[1:0] = {cal_blk_pdn, gx_pdn};
            LOCK_STATUS:
                rd_mux[0] = pll_locked;
            default:
                rd_mux = '0;
        endcase
    end

    //////////////////////////////
    // two-cycle read
    //////////////////////////////
    // first cycle stalls and captures, second cycle returns the data
    always_ff @(posedge phy_mgmt_clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_done <= 1'b0;
        else
            rd_done <= read & ~rd_done;
    end

    always_ff @(posedge phy_mgmt_clk)
    begin
        if (read && !rd_done)
            readdata <= rd_mux;
    end

    assign waitrequest = read & ~rd_done;

endmodule

// File: channel/ch_csr.sv
// channel register slave with the per-lane reset mask and lane status readback
`timescale 1ns/1ns
`include "lowlat_phy_cfg.svh"

module ch_csr
    import lowlat_phy_pkg::*;
(
    input  logic       phy_mgmt_clk,
    input  logic       rst_n,
    input  logic [5:0] address,
    input  logic       read,
    input  logic       write,
    input  mgmt_data_t writedata,
    input  lane_vec_t  tx_ready_lanes,
    input  lane_vec_t  rx_ready_lanes,
    input  lane_vec_t  rx_locked_lanes,
    output mgmt_data_t readdata,
    output logic       waitrequest,
    output lane_vec_t  lane_reset
);

    ch_reg_off_e offset;
    logic        rd_done;
    mgmt_data_t  rd_mux;

    assign offset = ch_reg_off_e'(address);

    //////////////////////////////
    // lane reset mask
    //////////////////////////////
    // a set bit holds that lane out of ready
    always_ff @(posedge phy_mgmt_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lane_reset <= '0;
        end
        else if (write && (offset == LANE_RESET))
        begin
            lane_reset <= writedata[`LOWLAT_LANES-1:0];
        end
    end

    //////////////////////////////
    // readback
    //////////////////////////////
    // status words are lane vectors, zero-extended
    always_comb
    begin
        rd_mux = '0;
        case (offset)
            LANE_RESET:
            begin
                rd_mux[`LOWLAT_LANES-1:0] = lane_reset;
            end
            TX_READY:
            begin
                rd_mux[`LOWLAT_LANES-1:0] = tx_ready_lanes;
            end
            RX_READY:
            begin
                rd_mux[`LOWLAT_LANES-1:0] = rx_ready_lanes;
            end
            RX_LOCKED:
            begin
                rd_mux[`LOWLAT_LANES-1:0] = rx_locked_lanes;
            end
            default:
            begin
                rd_mux = '0;
            end
        endcase
    end

    //////////////////////////////
    // two-cycle read
    //////////////////////////////
    always_ff @(posedge phy_mgmt_clk or negedge rst_n)
    begin
        if (!rst_n)
            rd_done <= 1'b0;
        else
            rd_done <= read & ~rd_done;
    end

    // capture during the stall cycle
    always_ff @(posedge phy_mgmt_clk)
    begin
        if (read && !rd_done)
            readdata <= rd_mux;
    end

    // drops once the captured word is on readdata
    assign waitrequest = read & ~rd_done;

endmodule

// File: channel/ch_reset_seq.sv
// per-lane reset sequencer that raises tx and rx readiness after the settling delays
`timescale 1ns/1ns
`include "lowlat_phy_cfg.svh"

module ch_reset_seq
    import lowlat_phy_pkg::*;
(
    input  logic      phy_mgmt_clk,
    input  logic      rst_n,
    input  logic      pll_locked,
    input  logic      pll_pdn,
    input  logic      gx_pdn,
    input  lane_vec_t rx_is_lockedtodata,
    input  lane_vec_t lane_reset,
    output lane_vec_t tx_ready_lanes,
    output lane_vec_t rx_ready_lanes,
    output lane_vec_t rx_locked_lanes
);

    // counter widths hold the last count before ready
    localparam int tx_cnt_w = $clog2(`TX_READY_DLY);
    localparam int rx_cnt_w = $clog2(`RX_READY_DLY);
    localparam logic [tx_cnt_w-1:0] tx_last = tx_cnt_w'(`TX_READY_DLY - 1);
    localparam logic [rx_cnt_w-1:0] rx_last = rx_cnt_w'(`RX_READY_DLY - 1);

    // PLL side is shared by all lanes
    logic pll_good;

    assign pll_good = pll_locked & ~pll_pdn & ~gx_pdn;

    genvar n;
    generate
        for (n = 0; n < `LOWLAT_LANES; n++)
        begin : g_lane
            logic [`SYNC_STAGES-1:0] rx_sync;
            logic [tx_cnt_w-1:0]     tx_cnt;
            logic [rx_cnt_w-1:0]     rx_cnt;
            logic                    tx_cond;
            logic                    rx_cond;

            //////////////////////////////
            // rx lock synchronizer
            //////////////////////////////
            always_ff @(posedge phy_mgmt_clk or negedge rst_n)
            begin
                if (!rst_n)
                    rx_sync <= '0;
                else
                    rx_sync <= {rx_sync[`SYNC_STAGES-2:0], rx_is_lockedtodata[n]};
            end

            assign rx_locked_lanes[n] = rx_sync[`SYNC_STAGES-1];

            assign tx_cond = pll_good & ~lane_reset[n];
            assign rx_cond = rx_sync[`SYNC_STAGES-1] & ~lane_reset[n];

            //////////////////////////////
            // settling counters
            //////////////////////////////
            // any break in the condition clears ready and restarts the count
            always_ff @(posedge phy_mgmt_clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    tx_cnt            <= '0;
                    tx_ready_lanes[n] <= 1'b0;
                end
                else if (!tx_cond)
                begin
                    tx_cnt            <= '0;
                    tx_ready_lanes[n] <= 1'b0;
                end
                else if (tx_cnt == tx_last)
                begin
                    tx_ready_lanes[n] <= 1'b1;
                end
                else
                begin
                    tx_cnt <= tx_cnt + 1'b1;
                end
            end

            always_ff @(posedge phy_mgmt_clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    rx_cnt            <= '0;
                    rx_ready_lanes[n] <= 1'b0;
                end
                else if (!rx_cond)
                begin
                    rx_cnt            <= '0;
                    rx_ready_lanes[n] <= 1'b0;
                end
                else if (rx_cnt == rx_last)
                begin
                    rx_ready_lanes[n] <= 1'b1;
                end
                else
                begin
                    rx_cnt <= rx_cnt + 1'b1;
                end
            end
        end
    endgenerate

endmodule

// File: rtl/lowlat_phy_top.sv
// top level of the PHY management and readiness logic, instantiated by the system or testbench
`timescale 1ns/1ns

module lowlat_phy_top
    import lowlat_phy_pkg::*;
(
    input  logic       phy_mgmt_clk,
    input  logic       rst_n,
    input  mgmt_addr_t phy_mgmt_address,
    input  logic       phy_mgmt_read,
    input  logic       phy_mgmt_write,
    input  mgmt_data_t phy_mgmt_writedata,
    input  logic       pll_lock_raw,
    input  lane_vec_t  rx_is_lockedtodata,
    output mgmt_data_t phy_mgmt_readdata,
    output logic       phy_mgmt_waitrequest,
    output logic       pll_pdn,
    output logic       gx_pdn,
    output logic       cal_blk_pdn,
    output logic       pll_locked,
    output logic       tx_ready,
    output logic       rx_ready
);

    // slave side of the decoder
    logic       pma_read;
    logic       pma_write;
    mgmt_data_t pma_readdata;
    logic       pma_waitrequest;
    logic       ch_read;
    logic       ch_write;
    mgmt_data_t ch_readdata;
    logic       ch_waitrequest;

    // lane status
    lane_vec_t lane_reset;
    lane_vec_t tx_ready_lanes;
    lane_vec_t rx_ready_lanes;
    lane_vec_t rx_locked_lanes;

    //////////////////////////////
    // management bus
    //////////////////////////////
    phy_mgmt_decoder u_decoder (
        .address         (phy_mgmt_address),
        .read            (phy_mgmt_read),
        .write           (phy_mgmt_write),
        .pma_readdata    (pma_readdata),
        .pma_waitrequest (pma_waitrequest),
        .ch_readdata     (ch_readdata),
        .ch_waitrequest  (ch_waitrequest),
        .pma_read        (pma_read),
        .pma_write       (pma_write),
        .ch_read         (ch_read),
        .ch_write        (ch_write),
        .readdata        (phy_mgmt_readdata),
        .waitrequest     (phy_mgmt_waitrequest)
    );

    pma_ctrl_regs u_pma_ctrl (
        .phy_mgmt_clk (phy_mgmt_clk),
        .rst_n        (rst_n),
        .address      (phy_mgmt_address[1:0]),
        .read         (pma_read),
        .write        (pma_write),
        .writedata    (phy_mgmt_writedata),
        .pll_lock_raw (pll_lock_raw),
        .readdata     (pma_readdata),
        .waitrequest  (pma_waitrequest),
        .pll_pdn      (pll_pdn),
        .gx_pdn       (gx_pdn),
        .cal_blk_pdn  (cal_blk_pdn),
        .pll_locked   (pll_locked)
    );

    ch_csr u_ch_csr (
        .phy_mgmt_clk    (phy_mgmt_clk),
        .rst_n           (rst_n),
        .address         (phy_mgmt_address[5:0]),
        .read            (ch_read),
        .write           (ch_write),
        .writedata       (phy_mgmt_writedata),
        .tx_ready_lanes  (tx_ready_lanes),
        .rx_ready_lanes  (rx_ready_lanes),
        .rx_locked_lanes (rx_locked_lanes),
        .readdata        (ch_readdata),
        .waitrequest     (ch_waitrequest),
        .lane_reset      (lane_reset)
    );

    //////////////////////////////
    // readiness
    //////////////////////////////
    ch_reset_seq u_reset_seq (
        .phy_mgmt_clk       (phy_mgmt_clk),
        .rst_n              (rst_n),
        .pll_locked         (pll_locked),
        .pll_pdn            (pll_pdn),
        .gx_pdn             (gx_pdn),
        .rx_is_lockedtodata (rx_is_lockedtodata),
        .lane_reset         (lane_reset),
        .tx_ready_lanes     (tx_ready_lanes),
        .rx_ready_lanes     (rx_ready_lanes),
        .rx_locked_lanes    (rx_locked_lanes)
    );

    // link is ready only when every lane is
    assign tx_ready = &tx_ready_lanes;
    assign rx_ready = &rx_ready_lanes;

endmodule

// File: verif/tb_lowlat_phy.sv
// random-stimulus testbench for lowlat_phy_top, checks the bus and lane readiness against a model
`timescale 1ns/1ns
`include "lowlat_phy_cfg.svh"

module tb_lowlat_phy
    import lowlat_phy_pkg::*;
();

    localparam int sel_tx   = 0;
    localparam int sel_rx   = 1;
    localparam int sel_lock = 2;

    logic       phy_mgmt_clk;
    logic       rst_n;
    mgmt_addr_t phy_mgmt_address;
    logic       phy_mgmt_read;
    logic       phy_mgmt_write;
    mgmt_data_t phy_mgmt_writedata;
    logic       pll_lock_raw;
    lane_vec_t  rx_is_lockedtodata;
    mgmt_data_t phy_mgmt_readdata;
    logic       phy_mgmt_waitrequest;
    logic       pll_pdn;
    logic       gx_pdn;
    logic       cal_blk_pdn;
    logic       pll_locked;
    logic       tx_ready;
    logic       rx_ready;

    // model state
    logic [`SYNC_STAGES-1:0] lock_pipe_m;
    logic [`SYNC_STAGES-1:0] rx_pipe_m [`LOWLAT_LANES];
    logic                    pll_pdn_m;
    logic                    gx_pdn_m;
    logic                    cal_pdn_m;
    lane_vec_t               lane_reset_m;
    int                      tx_run_m [`LOWLAT_LANES];
    int                      rx_run_m [`LOWLAT_LANES];

    lowlat_phy_top DUT (
        .phy_mgmt_clk         (phy_mgmt_clk),
        .rst_n                (rst_n),
        .phy_mgmt_address     (phy_mgmt_address),
        .phy_mgmt_read        (phy_mgmt_read),
        .phy_mgmt_write       (phy_mgmt_write),
        .phy_mgmt_writedata   (phy_mgmt_writedata),
        .pll_lock_raw         (pll_lock_raw),
        .rx_is_lockedtodata   (rx_is_lockedtodata),
        .phy_mgmt_readdata    (phy_mgmt_readdata),
        .phy_mgmt_waitrequest (phy_mgmt_waitrequest),
        .pll_pdn              (pll_pdn),
        .gx_pdn               (gx_pdn),
        .cal_blk_pdn          (cal_blk_pdn),
        .pll_locked           (pll_locked),
        .tx_ready             (tx_ready),
        .rx_ready             (rx_ready)
    );

    always #4 phy_mgmt_clk = ~phy_mgmt_clk;

    //////////////////////////////
    // failure reporting
    //////////////////////////////
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_run($sformatf("FAIL %0t %s expected 0x%0h got 0x%0h", $time, name, exp, act));
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    // address map as ranges
    function automatic logic in_pma(input mgmt_addr_t addr);
        return (addr >= `PMA_CTRL_BASE) && (addr < `PMA_CTRL_BASE + 32);
    endfunction

    function automatic logic in_channel(input mgmt_addr_t addr);
        return (addr >= `CH_BASE) && (addr < `CH_BASE + 64);
    endfunction

    function automatic lane_vec_t expected_tx_lanes();
        lane_vec_t v;
        for (int n = 0; n < `LOWLAT_LANES; n++)
            v[n] = (tx_run_m[n] >= `TX_READY_DLY);
        return v;
    endfunction

    function automatic lane_vec_t expected_rx_lanes();
        lane_vec_t v;
        for (int n = 0; n < `LOWLAT_LANES; n++)
            v[n] = (rx_run_m[n] >= `RX_READY_DLY);
        return v;
    endfunction

    function automatic lane_vec_t expected_rx_locked();
        lane_vec_t v;
        for (int n = 0; n < `LOWLAT_LANES; n++)
            v[n] = rx_pipe_m[n][`SYNC_STAGES-1];
        return v;
    endfunction

    function automatic mgmt_data_t expected_read(input mgmt_addr_t addr);
        mgmt_data_t d;
        int         off;
        d = '0;
        if (in_pma(addr))
        begin
            // PMA slave only sees two address bits, so the region aliases every 4 words
            off = (addr - `PMA_CTRL_BASE) % 4;
            if (off == PLL_PDN)
                d[0] = pll_pdn_m;
            else if (off == GX_PDN)
                d[1:0] = {cal_pdn_m, gx_pdn_m};
            else if (off == LOCK_STATUS)
                d[0] = lock_pipe_m[`SYNC_STAGES-1];
        end
        else if (in_channel(addr))
        begin
            off = addr - `CH_BASE;
            if (off == LANE_RESET)
                d[`LOWLAT_LANES-1:0] = lane_reset_m;
            else if (off == TX_READY)
                d[`LOWLAT_LANES-1:0] = expected_tx_lanes();
            else if (off == RX_READY)
                d[`LOWLAT_LANES-1:0] = expected_rx_lanes();
            else if (off == RX_LOCKED)
                d[`LOWLAT_LANES-1:0] = expected_rx_locked();
        end
        return d;
    endfunction

    // run lengths of each lane's ready condition, saturating at the delay
    always @(posedge phy_mgmt_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            lock_pipe_m  <= '0;
            pll_pdn_m    <= 1'b0;
            gx_pdn_m     <= 1'b0;
            cal_pdn_m    <= 1'b0;
            lane_reset_m <= '0;
            for (int n = 0; n < `LOWLAT_LANES; n++)
            begin
                rx_pipe_m[n] <= '0;
                tx_run_m[n]  <= 0;
                rx_run_m[n]  <= 0;
            end
        end
        else
        begin
            lock_pipe_m <= {lock_pipe_m[`SYNC_STAGES-2:0], pll_lock_raw};
            if (phy_mgmt_write && in_pma(phy_mgmt_address))
            begin
                if ((phy_mgmt_address - `PMA_CTRL_BASE) % 4 == PLL_PDN)
                    pll_pdn_m <= phy_mgmt_writedata[0];
                else if ((phy_mgmt_address - `PMA_CTRL_BASE) % 4 == GX_PDN)
                begin
                    gx_pdn_m  <= phy_mgmt_writedata[0];
                    cal_pdn_m <= phy_mgmt_writedata[1];
                end
            end
            if (phy_mgmt_write && (phy_mgmt_address == `CH_BASE + LANE_RESET))
                lane_reset_m <= phy_mgmt_writedata[`LOWLAT_LANES-1:0];
            for (int n = 0; n < `LOWLAT_LANES; n++)
            begin
                rx_pipe_m[n] <= {rx_pipe_m[n][`SYNC_STAGES-2:0], rx_is_lockedtodata[n]};
                if (lock_pipe_m[`SYNC_STAGES-1] && !pll_pdn_m && !gx_pdn_m && !lane_reset_m[n])
                    tx_run_m[n] <= (tx_run_m[n] < `TX_READY_DLY) ? tx_run_m[n] + 1 : tx_run_m[n];
                else
                    tx_run_m[n] <= 0;
                if (rx_pipe_m[n][`SYNC_STAGES-1] && !lane_reset_m[n])
                    rx_run_m[n] <= (rx_run_m[n] < `RX_READY_DLY) ? rx_run_m[n] + 1 : rx_run_m[n];
                else
                    rx_run_m[n] <= 0;
            end
        end
    end

    // outputs compared every cycle away from the driving edge
    always @(negedge phy_mgmt_clk)
    begin
        if (rst_n)
        begin
            assert (pll_locked === lock_pipe_m[`SYNC_STAGES-1])
                else report_mismatch("pll_locked", lock_pipe_m[`SYNC_STAGES-1], pll_locked);
            assert (pll_pdn === pll_pdn_m)
                else report_mismatch("pll_pdn", pll_pdn_m, pll_pdn);
            assert (gx_pdn === gx_pdn_m)
                else report_mismatch("gx_pdn", gx_pdn_m, gx_pdn);
            assert (cal_blk_pdn === cal_pdn_m)
                else report_mismatch("cal_blk_pdn", cal_pdn_m, cal_blk_pdn);
            assert (tx_ready === &expected_tx_lanes())
                else report_mismatch("tx_ready", &expected_tx_lanes(), tx_ready);
            assert (rx_ready === &expected_rx_lanes())
                else report_mismatch("rx_ready", &expected_rx_lanes(), rx_ready);
        end
    end

    //////////////////////////////
    // bus and wait tasks
    //////////////////////////////
    task automatic bus_write(input mgmt_addr_t addr, input mgmt_data_t data);
        @(posedge phy_mgmt_clk);
        phy_mgmt_address   <= addr;
        phy_mgmt_writedata <= data;
        phy_mgmt_write     <= 1'b1;
        @(posedge phy_mgmt_clk);
        phy_mgmt_write <= 1'b0;
    endtask

    task automatic bus_read(input mgmt_addr_t addr, output mgmt_data_t data);
        mgmt_data_t exp;
        int         stall;
        @(posedge phy_mgmt_clk);
        phy_mgmt_address <= addr;
        phy_mgmt_read    <= 1'b1;
        @(negedge phy_mgmt_clk);
        // slave captures what the model holds in this first cycle
        exp   = expected_read(addr);
        stall = 0;
        while (phy_mgmt_waitrequest !== 1'b0 && stall <= 10)
        begin
            @(negedge phy_mgmt_clk);
            stall++;
        end
        if (stall > 10)
            fail_run($sformatf("read of address 0x%0h still stalled after 10 cycles", addr));
        else
        begin
            assert (stall == ((in_pma(addr) || in_channel(addr)) ? 1 : 0))
                else report_mismatch("phy_mgmt_waitrequest cycles",
                                     (in_pma(addr) || in_channel(addr)) ? 1 : 0, stall);
            assert (phy_mgmt_readdata === exp)
                else report_mismatch("phy_mgmt_readdata", exp, phy_mgmt_readdata);
            data = phy_mgmt_readdata;
            @(posedge phy_mgmt_clk);
            phy_mgmt_read <= 1'b0;
        end
    endtask

    function automatic logic watched_value(input int sel);
        if (sel == sel_tx)
            return tx_ready;
        else if (sel == sel_rx)
            return rx_ready;
        return pll_locked;
    endfunction

    function automatic string watched_name(input int sel);
        if (sel == sel_tx)
            return "tx_ready";
        else if (sel == sel_rx)
            return "rx_ready";
        return "pll_locked";
    endfunction

    // counts falling edges until the output reaches the level
    task automatic wait_for(input int sel, input logic level, input int limit, output int cycles);
        cycles = 0;
        @(negedge phy_mgmt_clk);
        while (watched_value(sel) !== level && cycles < limit)
        begin
            cycles++;
            @(negedge phy_mgmt_clk);
        end
        if (watched_value(sel) !== level)
            fail_run($sformatf("timed out after %0d cycles waiting for %s to become %0b",
                               limit, watched_name(sel), level));
    endtask

    // brief lanes hold every level for less than the rx settling time
    task automatic toggle_rx(input lane_vec_t brief, input int cycles);
        int        hold [`LOWLAT_LANES];
        lane_vec_t level;
        level = rx_is_lockedtodata;
        for (int n = 0; n < `LOWLAT_LANES; n++)
            hold[n] = 1;
        repeat (cycles)
        begin
            @(posedge phy_mgmt_clk);
            for (int n = 0; n < `LOWLAT_LANES; n++)
            begin
                hold[n]--;
                if (hold[n] == 0)
                begin
                    level[n] = ~level[n];
                    if (brief[n])
                        hold[n] = $urandom_range(1, `RX_READY_DLY - 1);
                    else
                        hold[n] = $urandom_range(`RX_READY_DLY / 2, `RX_READY_DLY * 3);
                end
            end
            rx_is_lockedtodata <= level;
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial
    begin
        mgmt_addr_t addr;
        mgmt_data_t data;
        lane_vec_t  mask;
        lane_vec_t  brief;
        int         cycles;

        void'($urandom(32'h88d3a055));
        phy_mgmt_clk       = 1'b0;
        rst_n              = 1'b0;
        phy_mgmt_address   = '0;
        phy_mgmt_read      = 1'b0;
        phy_mgmt_write     = 1'b0;
        phy_mgmt_writedata = '0;
        pll_lock_raw       = 1'b0;
        rx_is_lockedtodata = '0;
        repeat (8) @(posedge phy_mgmt_clk);
        rst_n <= 1'b1;

        // reset values
        @(negedge phy_mgmt_clk);
        assert (!pll_pdn && !gx_pdn && !cal_blk_pdn && !tx_ready && !rx_ready)
            else fail_run("outputs not all low after reset");
        bus_read(`CH_BASE + LANE_RESET, data);
        assert (data === '0)
            else report_mismatch("LANE_RESET", 0, data);

        // random register traffic across every region
        for (int i = 0; i < 40; i++)
        begin
            case ($urandom_range(0, 3))
                0: addr = `PMA_CTRL_BASE + $urandom_range(0, 31);
                1: addr = `CH_BASE + $urandom_range(0, 63);
                2: addr = `RECONFIG_BASE + $urandom_range(0, 255);
                default: addr = $urandom_range(0, 1) ? $urandom_range(0, 'h1f)
                                                     : $urandom_range('h80, 'hff);
            endcase
            if ($urandom_range(0, 1))
                bus_write(addr, $urandom());
            bus_read(addr, data);
        end
        bus_write(`PMA_CTRL_BASE + PLL_PDN, 0);
        bus_write(`PMA_CTRL_BASE + GX_PDN, 0);
        bus_write(`CH_BASE + LANE_RESET, 0);

        // lock synchronizer and tx settling
        @(posedge phy_mgmt_clk);
        pll_lock_raw <= 1'b1;
        wait_for(sel_lock, 1'b1, 10, cycles);
        assert (cycles == `SYNC_STAGES)
            else report_mismatch("pll_locked delay", `SYNC_STAGES, cycles);
        bus_read(`PMA_CTRL_BASE + LOCK_STATUS, data);
        wait_for(sel_tx, 1'b1, `TX_READY_DLY + 4, cycles);
        bus_read(`CH_BASE + TX_READY, data);
        assert (data[`LOWLAT_LANES-1:0] === '1)
            else report_mismatch("TX_READY", {`LOWLAT_LANES{1'b1}}, data);
        bus_write(`PMA_CTRL_BASE + PLL_PDN, 1);
        wait_for(sel_tx, 1'b0, 4, cycles);
        bus_write(`PMA_CTRL_BASE + PLL_PDN, 0);
        wait_for(sel_tx, 1'b1, `TX_READY_DLY + 4, cycles);
        bus_write(`PMA_CTRL_BASE + GX_PDN, 3);
        wait_for(sel_tx, 1'b0, 4, cycles);
        bus_write(`PMA_CTRL_BASE + GX_PDN, 0);
        wait_for(sel_tx, 1'b1, `TX_READY_DLY + 4, cycles);
        @(posedge phy_mgmt_clk);
        pll_lock_raw <= 1'b0;
        wait_for(sel_lock, 1'b0, 10, cycles);
        assert (cycles == `SYNC_STAGES)
            else report_mismatch("pll_locked delay", `SYNC_STAGES, cycles);
        wait_for(sel_tx, 1'b0, 3, cycles);
        bus_read(`PMA_CTRL_BASE + LOCK_STATUS, data);
        @(posedge phy_mgmt_clk);
        pll_lock_raw <= 1'b1;
        wait_for(sel_tx, 1'b1, `TX_READY_DLY + `SYNC_STAGES + 4, cycles);

        // rx toggling with a few lanes that never settle
        brief = $urandom_range(1, (1 << `LOWLAT_LANES) - 2);
        fork
            toggle_rx(brief, 400);
            repeat (25)
            begin
                repeat ($urandom_range(2, 12)) @(posedge phy_mgmt_clk);
                bus_read(`CH_BASE + RX_LOCKED, data);
                bus_read(`CH_BASE + RX_READY, data);
                assert ((data[`LOWLAT_LANES-1:0] & brief) == '0)
                    else report_mismatch("RX_READY brief lanes", 0, data & brief);
            end
        join

        // lane reset mask
        @(posedge phy_mgmt_clk);
        rx_is_lockedtodata <= '1;
        wait_for(sel_rx, 1'b1, `RX_READY_DLY + `SYNC_STAGES + 4, cycles);
        repeat (3)
        begin
            mask = $urandom_range(1, (1 << `LOWLAT_LANES) - 1);
            bus_write(`CH_BASE + LANE_RESET, mask);
            bus_read(`CH_BASE + TX_READY, data);
            assert ((data[`LOWLAT_LANES-1:0] & mask) == '0)
                else report_mismatch("TX_READY masked lanes", 0, data & mask);
            bus_read(`CH_BASE + RX_READY, data);
            assert ((data[`LOWLAT_LANES-1:0] & mask) == '0)
                else report_mismatch("RX_READY masked lanes", 0, data & mask);
            @(negedge phy_mgmt_clk);
            assert (tx_ready === 1'b0 && rx_ready === 1'b0)
                else fail_run("tx_ready or rx_ready high while lanes are held in reset");
            bus_write(`CH_BASE + LANE_RESET, 0);
            wait_for(sel_tx, 1'b1, `TX_READY_DLY + 4, cycles);
            assert (cycles == `TX_READY_DLY)
                else report_mismatch("tx_ready settling after lane reset", `TX_READY_DLY, cycles);
            wait_for(sel_rx, 1'b1, `RX_READY_DLY + 4, cycles);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+common
common/lowlat_phy_pkg.sv
rtl/phy_mgmt_decoder.sv
pma_ctrl/pma_ctrl_regs.sv
channel/ch_csr.sv
channel/ch_reset_seq.sv
rtl/lowlat_phy_top.sv
verif/tb_lowlat_phy.sv
